/* common/bp_cfg.svh */
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// table index width, each table holds 2**BP_INDEX_W entries
`define BP_INDEX_W 8

// word-aligned pc
`define BP_ADDR_W 30

// local and global history widths
`define BP_BH_W 16
`define BP_GH_W 32

// weakly not taken / weakly local
`define BP_CTR_INIT 2'b01

`endif

/* common/bp_pkg.sv */
package bp_pkg;

`include "bp_cfg.svh"

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } kind_t;

    typedef logic [1:0] ctr2_t;

    typedef struct packed {
        logic [`BP_ADDR_W-1:0] pc;
        logic [`BP_BH_W-1:0]   bh;
        logic [`BP_GH_W-1:0]   gh;
        kind_t                 kind;
    } bp_lookup_t;

    // counters seen at prediction time, carried back at execute
    typedef struct packed {
        ctr2_t local_ctr;
        ctr2_t global_ctr;
        ctr2_t choice_ctr;
    } bp_pdch_t;

    typedef struct packed {
        logic     taken;
        logic     choice_g;
        bp_pdch_t pdch;
    } bp_pred_t;

    typedef struct packed {
        logic [`BP_ADDR_W-1:0] pc;
        logic [`BP_BH_W-1:0]   bh;
        logic [`BP_GH_W-1:0]   gh;
        kind_t                 kind;
        logic                  taken_real;
        bp_pdch_t              pdch;
    } bp_update_t;

    function automatic logic [`BP_INDEX_W-1:0] local_index(
        input logic [`BP_ADDR_W-1:0] pc,
        input logic [`BP_BH_W-1:0]   bh
    );
        return pc[`BP_INDEX_W+1:2] ^ bh[`BP_INDEX_W-1:0];
    endfunction

    function automatic logic [`BP_INDEX_W-1:0] global_index(
        input logic [`BP_ADDR_W-1:0] pc,
        input logic [`BP_GH_W-1:0]   gh
    );
        return pc[`BP_INDEX_W+1:2] ^ gh[`BP_INDEX_W-1:0];
    endfunction

    // one saturating step toward up or down
    function automatic ctr2_t ctr_step(input ctr2_t ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

endpackage

/* design/init_sweep_fsm.sv */
`timescale 1ns/100ps

module init_sweep_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic sweep_wrap,
    output logic sweep_en,
    output logic init_busy
);

    typedef enum logic {
        st_sweep = 1'b0,
        st_ready = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_sweep: begin
                if (sweep_wrap) begin
                    state_nxt = st_ready;
                end
            end
            // stays here until the next reset
            st_ready: state_nxt = st_ready;
            default:  state_nxt = st_sweep;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_sweep;
        end else begin
            state <= state_nxt;
        end
    end

    assign sweep_en  = (state == st_sweep);
    assign init_busy = (state == st_sweep);

endmodule

/* design/sweep_counter.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module sweep_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sweep_en,
    output logic [`BP_INDEX_W-1:0] sweep_idx,
    output logic                   sweep_wrap
);

    logic last_idx;

    assign last_idx = (sweep_idx == {`BP_INDEX_W{1'b1}});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_idx  <= '0;
            sweep_wrap <= 1'b0;
        end else if (sweep_en) begin
            sweep_idx  <= sweep_idx + `BP_INDEX_W'(1);
            // flags that the last entry has just been written
            sweep_wrap <= last_idx;
        end
    end

endmodule

/* predictor/local_pht.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module local_pht (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  bp_pkg::bp_lookup_t     lookup,
    input  logic                   train_en,
    input  bp_pkg::bp_update_t     update,
    input  logic                   sweep_en,
    input  logic [`BP_INDEX_W-1:0] sweep_idx,
    output bp_pkg::ctr2_t          ctr
);

    bp_pkg::ctr2_t          mem [2**`BP_INDEX_W];
    logic [`BP_INDEX_W-1:0] rd_idx;
    logic [`BP_INDEX_W-1:0] wr_idx;
    bp_pkg::ctr2_t          trained;

    assign rd_idx  = bp_pkg::local_index(lookup.pc, lookup.bh);
    assign wr_idx  = bp_pkg::local_index(update.pc, update.bh);
    assign trained = bp_pkg::ctr_step(update.pdch.local_ctr, update.taken_real);

    // sweep has priority, training is blocked then anyway
    always_ff @(posedge clk) begin
        if (sweep_en) begin
            mem[sweep_idx] <= `BP_CTR_INIT;
        end else if (train_en) begin
            mem[wr_idx] <= trained;
        end
    end

    // read register, held while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr <= `BP_CTR_INIT;
        end else if (!stall) begin
            ctr <= mem[rd_idx];
        end
    end

endmodule

/* predictor/global_pht.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module global_pht (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  bp_pkg::bp_lookup_t     lookup,
    input  logic                   train_en,
    input  bp_pkg::bp_update_t     update,
    input  logic                   sweep_en,
    input  logic [`BP_INDEX_W-1:0] sweep_idx,
    output bp_pkg::ctr2_t          ctr
);

    bp_pkg::ctr2_t          mem [2**`BP_INDEX_W];
    logic [`BP_INDEX_W-1:0] rd_idx;
    logic [`BP_INDEX_W-1:0] wr_idx;
    bp_pkg::ctr2_t          trained;

    // pc folded with global history
    assign rd_idx  = bp_pkg::global_index(lookup.pc, lookup.gh);
    assign wr_idx  = bp_pkg::global_index(update.pc, update.gh);
    assign trained = bp_pkg::ctr_step(update.pdch.global_ctr, update.taken_real);

    always_ff @(posedge clk) begin
        if (sweep_en) begin
            mem[sweep_idx] <= `BP_CTR_INIT;
        end else if (train_en) begin
            mem[wr_idx] <= trained;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr <= `BP_CTR_INIT;
        end else if (!stall) begin
            ctr <= mem[rd_idx];
        end
    end

endmodule

/* predictor/choice_table.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module choice_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  bp_pkg::bp_lookup_t     lookup,
    input  logic                   train_en,
    input  bp_pkg::bp_update_t     update,
    input  logic                   sweep_en,
    input  logic [`BP_INDEX_W-1:0] sweep_idx,
    output bp_pkg::ctr2_t          ctr
);

    bp_pkg::ctr2_t          mem [2**`BP_INDEX_W];
    logic [`BP_INDEX_W-1:0] rd_idx;
    logic [`BP_INDEX_W-1:0] wr_idx;
    logic                   disagree;
    logic                   global_right;
    bp_pkg::ctr2_t          trained;

    assign rd_idx = bp_pkg::global_index(lookup.pc, lookup.gh);
    assign wr_idx = bp_pkg::global_index(update.pc, update.gh);

    // nothing to learn when both predictors agreed
    assign disagree     = update.pdch.local_ctr[1] ^ update.pdch.global_ctr[1];
    assign global_right = (update.pdch.global_ctr[1] == update.taken_real);
    assign trained      = bp_pkg::ctr_step(update.pdch.choice_ctr, global_right);

    always_ff @(posedge clk) begin
        if (sweep_en) begin
            mem[sweep_idx] <= `BP_CTR_INIT;
        end else if (train_en && disagree) begin
            mem[wr_idx] <= trained;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr <= `BP_CTR_INIT;
        end else if (!stall) begin
            ctr <= mem[rd_idx];
        end
    end

endmodule

/* design/bp_top.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module bp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  bp_pkg::bp_lookup_t lookup,
    input  logic               update_en,
    input  bp_pkg::bp_update_t update,
    output bp_pkg::bp_pred_t   pred,
    output logic               init_busy
);

    logic                   sweep_en;
    logic                   sweep_wrap;
    logic [`BP_INDEX_W-1:0] sweep_idx;
    logic                   train_en;
    bp_pkg::kind_t          kind_q;
    bp_pkg::ctr2_t          local_ctr;
    bp_pkg::ctr2_t          global_ctr;
    bp_pkg::ctr2_t          choice_ctr;
    bp_pkg::ctr2_t          sel_ctr;

    // only direct conditional branches train, and never during init
    assign train_en = update_en && (update.kind == bp_pkg::direct_jump) && !init_busy;

    init_sweep_fsm init_sweep_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_wrap (sweep_wrap),
        .sweep_en   (sweep_en),
        .init_busy  (init_busy)
    );

    sweep_counter sweep_counter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_en   (sweep_en),
        .sweep_idx  (sweep_idx),
        .sweep_wrap (sweep_wrap)
    );

    local_pht local_pht_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .lookup    (lookup),
        .train_en  (train_en),
        .update    (update),
        .sweep_en  (sweep_en),
        .sweep_idx (sweep_idx),
        .ctr       (local_ctr)
    );

    global_pht global_pht_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .lookup    (lookup),
        .train_en  (train_en),
        .update    (update),
        .sweep_en  (sweep_en),
        .sweep_idx (sweep_idx),
        .ctr       (global_ctr)
    );

    choice_table choice_table_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .lookup    (lookup),
        .train_en  (train_en),
        .update    (update),
        .sweep_en  (sweep_en),
        .sweep_idx (sweep_idx),
        .ctr       (choice_ctr)
    );

    // kind follows the counters through the read stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= bp_pkg::not_jump;
        end else if (!stall) begin
            kind_q <= lookup.kind;
        end
    end

    assign sel_ctr = choice_ctr[1] ? global_ctr : local_ctr;

    // ret, indirect, call and jump always taken
    assign pred.taken = kind_q[2] | ((kind_q == bp_pkg::direct_jump) & sel_ctr[1]);
    assign pred.choice_g        = choice_ctr[1];
    assign pred.pdch.local_ctr  = local_ctr;
    assign pred.pdch.global_ctr = global_ctr;
    assign pred.pdch.choice_ctr = choice_ctr;

endmodule

/* testbench/bp_properties.sv */
`timescale 1ns/100ps

module bp_properties (
    input logic             clk,
    input logic             rst_n,
    input logic             stall,
    input logic             init_busy,
    input bp_pkg::bp_pred_t pred
);

    int assert_fails = 0;

    // 256 sweep writes plus the step into ready
    init_done_in_time: assert property (@(posedge clk) $rose(rst_n) |-> ##[0:258] !init_busy)
        else begin
            assert_fails++;
            $error("init sweep still busy 258 cycles after reset release");
        end

    pred_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (!init_busy && $past(stall)) |-> $stable(pred))
        else begin
            assert_fails++;
            $error("pred changed across a stalled cycle");
        end

    // the sweep runs once per reset
    init_stays_done: assert property (@(posedge clk) disable iff (!rst_n)
        !init_busy |=> !init_busy)
        else begin
            assert_fails++;
            $error("init sweep restarted without a reset");
        end

endmodule

bind bp_top bp_properties bp_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .init_busy (init_busy),
    .pred      (pred)
);

/* testbench/tb_bp.sv */
`timescale 1ns/100ps

`include "bp_cfg.svh"

module tb_bp;

    localparam int timeout_cycles = 4000;
    localparam int table_size     = 2**`BP_INDEX_W;

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               update_en;
    bp_pkg::bp_lookup_t lookup;
    bp_pkg::bp_update_t update;
    bp_pkg::bp_pred_t   pred;
    logic               init_busy;

    bp_pkg::ctr2_t      local_m [table_size];
    bp_pkg::ctr2_t      global_m [table_size];
    bp_pkg::ctr2_t      choice_m [table_size];
    bp_pkg::bp_pred_t   exp_pred;
    logic               exp_valid;
    logic               checking;
    int                 errors;
    int                 checks;
    int                 cycles;

    bp_top bp_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .lookup    (lookup),
        .update_en (update_en),
        .update    (update),
        .pred      (pred),
        .init_busy (init_busy)
    );

    always #4 clk = ~clk;

    function automatic bp_pkg::ctr2_t sat_step(input bp_pkg::ctr2_t c, input logic up);
        if (up) begin
            return (c == 2'b11) ? 2'b11 : c + 2'b01;
        end
        return (c == 2'b00) ? 2'b00 : c - 2'b01;
    endfunction

    function automatic bp_pkg::bp_pred_t predict_ref(input bp_pkg::bp_lookup_t l);
        bp_pkg::bp_pred_t       p;
        logic [`BP_INDEX_W-1:0] li;
        logic [`BP_INDEX_W-1:0] gi;
        li = bp_pkg::local_index(l.pc, l.bh);
        gi = bp_pkg::global_index(l.pc, l.gh);
        p.pdch     = {local_m[li], global_m[gi], choice_m[gi]};
        p.choice_g = choice_m[gi][1];
        case (l.kind)
            bp_pkg::direct_jump: p.taken = p.choice_g ? global_m[gi][1] : local_m[li][1];
            bp_pkg::ret, bp_pkg::indirect_jump, bp_pkg::call, bp_pkg::jump: p.taken = 1'b1;
            default: p.taken = 1'b0;
        endcase
        return p;
    endfunction

    task automatic train_ref(input bp_pkg::bp_update_t u);
        logic [`BP_INDEX_W-1:0] li;
        logic [`BP_INDEX_W-1:0] gi;
        li = bp_pkg::local_index(u.pc, u.bh);
        gi = bp_pkg::global_index(u.pc, u.gh);
        if (u.kind == bp_pkg::direct_jump) begin
            local_m[li]  = sat_step(u.pdch.local_ctr, u.taken_real);
            global_m[gi] = sat_step(u.pdch.global_ctr, u.taken_real);
            if (u.pdch.local_ctr[1] != u.pdch.global_ctr[1]) begin
                choice_m[gi] = sat_step(u.pdch.choice_ctr,
                                        u.pdch.global_ctr[1] == u.taken_real);
            end
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic bp_pkg::bp_lookup_t rand_lookup(input logic direct_only);
        bp_pkg::bp_lookup_t l;
        // small pc and history ranges so entries get reused
        l.pc = `BP_ADDR_W'($urandom_range(0, 31) << 2);
        l.bh = `BP_BH_W'($urandom_range(0, 7));
        l.gh = `BP_GH_W'($urandom_range(0, 15));
        case (direct_only ? 9 : $urandom_range(0, 9))
            0: l.kind = bp_pkg::not_jump;
            1: l.kind = bp_pkg::ret;
            2: l.kind = bp_pkg::indirect_jump;
            3: l.kind = bp_pkg::call;
            4: l.kind = bp_pkg::jump;
            default: l.kind = bp_pkg::direct_jump;
        endcase
        return l;
    endfunction

    // lookup, then echo the carried counters back as the update
    task automatic run_branch(input bp_pkg::bp_lookup_t l, input logic taken_real,
                              input logic do_update, output bp_pkg::bp_pred_t got);
        @(negedge clk);
        stall     = 1'b0;
        update_en = 1'b0;
        lookup    = l;
        @(negedge clk);
        got       = pred;
        update    = {l.pc, l.bh, l.gh, l.kind, taken_real, got.pdch};
        update_en = do_update;
    endtask

    // expectation taken before this edge's training, as the tables read old data
    always @(posedge clk) begin
        if (checking) begin
            if (!stall) begin
                exp_pred  = predict_ref(lookup);
                exp_valid = 1'b1;
            end
            if (update_en) begin
                train_ref(update);
            end
        end
    end

    always @(negedge clk) begin
        if (exp_valid) begin
            check_val("pred.taken", pred.taken, exp_pred.taken);
            check_val("pred.choice_g", pred.choice_g, exp_pred.choice_g);
            check_val("pred.pdch", pred.pdch, exp_pred.pdch);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        bp_pkg::bp_pred_t   got;
        bp_pkg::bp_lookup_t l;
        int                 init_wait;
        void'($urandom(32'h303a_4eda));
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        update_en = 1'b0;
        lookup    = '0;
        update    = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        exp_valid = 1'b0;
        checking  = 1'b0;
        for (int i = 0; i < table_size; i++) begin
            local_m[i]  = 2'b01;
            global_m[i] = 2'b01;
            choice_m[i] = 2'b01;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // one sweep write per entry plus the step into ready
        init_wait = 0;
        while (init_busy !== 1'b0) begin
            @(negedge clk);
            init_wait++;
        end
        check_val("init_busy cycles", init_wait, 257);
        @(negedge clk);
        checking = 1'b1;

        // fresh tables
        for (int i = 0; i < 8; i++) begin
            run_branch(rand_lookup(1'b1), 1'b0, 1'b0, got);
            check_val("pred.pdch", got.pdch, 6'b01_01_01);
        end
        for (int i = 0; i < 30; i++) begin
            run_branch(rand_lookup(1'b0), 1'($urandom()), 1'b1, got);
        end

        // saturation, then updates that must not train
        l = {30'h0000_0123, 16'h0005, 32'h0000_0009, bp_pkg::direct_jump};
        for (int i = 0; i < 6; i++) begin
            run_branch(l, 1'b1, 1'b1, got);
        end
        check_val("pred.pdch.local_ctr", got.pdch.local_ctr, 2'b11);
        check_val("pred.pdch.global_ctr", got.pdch.global_ctr, 2'b11);
        l.kind = bp_pkg::not_jump;
        for (int i = 0; i < 3; i++) begin
            run_branch(l, 1'b0, 1'b1, got);
        end
        l.kind = bp_pkg::direct_jump;
        for (int i = 0; i < 3; i++) begin
            run_branch(l, 1'b0, 1'b0, got);
        end
        check_val("pred.pdch.local_ctr", got.pdch.local_ctr, 2'b11);

        // outcome follows gh bit 0 while bh stays fixed
        for (int i = 0; i < 16; i++) begin
            l = {30'h0000_0300, 16'h0003, 32'(i % 2), bp_pkg::direct_jump};
            run_branch(l, i[0], 1'b1, got);
        end
        check_val("pred.choice_g", got.choice_g, 1'b1);

        for (int i = 0; i < 20; i++) begin
            run_branch(rand_lookup(1'b0), 1'($urandom()), 1'b1, got);
            repeat ($urandom_range(1, 6)) begin
                @(negedge clk);
                stall     = 1'b1;
                update_en = 1'b0;
                lookup    = rand_lookup(1'b0);
            end
        end

        for (int i = 0; i < 500; i++) begin
            run_branch(rand_lookup(1'b0), 1'($urandom()), $urandom_range(0, 3) != 0, got);
        end

        @(negedge clk);
        update_en = 1'b0;
        repeat (2) @(negedge clk);
        errors += bp_top_inst.bp_properties_inst.assert_fails;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+common
common/bp_pkg.sv
design/init_sweep_fsm.sv
design/sweep_counter.sv
predictor/local_pht.sv
predictor/global_pht.sv
predictor/choice_table.sv
design/bp_top.sv
testbench/bp_properties.sv
testbench/tb_bp.sv
